//--- hdl/cmul_pkg.sv
`default_nettype none

package cmul_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int ACC_W     = 32;
    localparam int SEL_W     = 4;
    localparam int NUM_TERMS = 6;
    localparam int NUM_COEF  = 12;
    localparam int SHIFT_W   = 5;
    localparam int PIPE_LAT  = 3;
    localparam int NUM_SEL   = 2 ** SEL_W;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [SEL_W-1:0]    coef_sel_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // one signed power-of-two term.
    typedef struct packed {
        logic               en;
        logic               neg;
        logic [SHIFT_W-1:0] shift;
    } csd_digit_s;

    typedef csd_digit_s [NUM_TERMS-1:0] csd_recipe_t;

    typedef struct packed {
        logic                 valid;
        acc_t [NUM_TERMS-1:0] term;
    } term_bundle_s;

    // carry still has weight one, cpa applies the shift.
    typedef struct packed {
        logic valid;
        acc_t sum;
        acc_t carry;
    } cs_pair_s;

    localparam csd_digit_s CSD_OFF = '0;

    function automatic csd_digit_s csd_pos(input int sh);
        return '{en: 1'b1, neg: 1'b0, shift: SHIFT_W'(sh)};
    endfunction

    function automatic csd_digit_s csd_neg(input int sh);
        return '{en: 1'b1, neg: 1'b1, shift: SHIFT_W'(sh)};
    endfunction

    // each recipe lists digit 5 first, digit 0 last.
    localparam csd_recipe_t CSD_TABLE [NUM_SEL] = '{
        // -835
        '{CSD_OFF, csd_pos(0), csd_neg(2), csd_neg(6), csd_pos(8), csd_neg(10)},
        // -146
        '{CSD_OFF, CSD_OFF, CSD_OFF, csd_neg(1), csd_neg(4), csd_neg(7)},
        // 1221
        '{CSD_OFF, csd_pos(0), csd_pos(2), csd_neg(6), csd_pos(8), csd_pos(10)},
        // 367
        '{CSD_OFF, CSD_OFF, csd_neg(0), csd_neg(4), csd_neg(7), csd_pos(9)},
        // -1961
        '{CSD_OFF, csd_neg(0), csd_neg(3), csd_neg(5), csd_pos(7), csd_neg(11)},
        // -1021
        '{CSD_OFF, CSD_OFF, CSD_OFF, csd_neg(0), csd_pos(2), csd_neg(10)},
        // 3226
        '{csd_pos(1), csd_neg(3), csd_pos(5), csd_pos(7), csd_neg(10), csd_pos(12)},
        // 2242
        '{CSD_OFF, CSD_OFF, csd_pos(1), csd_neg(6), csd_pos(8), csd_pos(11)},
        // -5415
        '{csd_pos(0), csd_neg(3), csd_neg(5), csd_neg(8), csd_neg(10), csd_neg(12)},
        // -5548
        '{csd_pos(2), csd_pos(4), csd_pos(6), csd_pos(9), csd_pos(11), csd_neg(13)},
        // 12555
        '{csd_neg(0), csd_neg(2), csd_pos(4), csd_pos(8), csd_neg(12), csd_pos(14)},
        // 33782
        '{CSD_OFF, CSD_OFF, csd_neg(1), csd_neg(3), csd_pos(10), csd_pos(15)},
        // unused selects.
        '0,
        '0,
        '0,
        '0
    };

endpackage

`default_nettype wire

//--- hdl/csd_partial_gen.sv
`timescale 1ns/1ps
`default_nettype none

module csd_partial_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  cmul_pkg::sample_t      in_x,
    input  cmul_pkg::coef_sel_t    in_sel,
    output cmul_pkg::term_bundle_s terms
);

    cmul_pkg::acc_t                                 x_ext;
    cmul_pkg::csd_recipe_t                          recipe;
    cmul_pkg::acc_t [cmul_pkg::NUM_TERMS-1:0]       term_d;
    cmul_pkg::acc_t [cmul_pkg::NUM_TERMS-1:0]       term_q;
    logic                                           valid_q;

    // every term is built from the sign-extended sample.
    assign x_ext = {{(cmul_pkg::ACC_W - cmul_pkg::SAMPLE_W){in_x[cmul_pkg::SAMPLE_W-1]}}, in_x};

    assign recipe = cmul_pkg::CSD_TABLE[in_sel];

    always_comb begin
        cmul_pkg::acc_t shifted;
        shifted = '0;
        for (int i = 0; i < cmul_pkg::NUM_TERMS; i++) begin
            shifted = x_ext <<< recipe[i].shift;
            if (!recipe[i].en) begin
                term_d[i] = '0;
            end else if (recipe[i].neg) begin
                term_d[i] = -shifted;
            end else begin
                term_d[i] = shifted;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // terms only load on a strobe.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            term_q <= term_d;
        end
    end

    assign terms = '{valid: valid_q, term: term_q};

endmodule

`default_nettype wire

//--- hdl/csa_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module csa_reduce (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cmul_pkg::term_bundle_s terms,
    output cmul_pkg::cs_pair_s     pair
);

    cmul_pkg::acc_t s1;
    cmul_pkg::acc_t c1;
    cmul_pkg::acc_t s2;
    cmul_pkg::acc_t c2;
    cmul_pkg::acc_t s3;
    cmul_pkg::acc_t c3;
    cmul_pkg::acc_t s4;
    cmul_pkg::acc_t c4;

    cmul_pkg::acc_t sum_q;
    cmul_pkg::acc_t carry_q;
    logic           valid_q;

    // full adder per bit, carry out has weight two.
    function automatic void csa3(
        input  cmul_pkg::acc_t a,
        input  cmul_pkg::acc_t b,
        input  cmul_pkg::acc_t c,
        output cmul_pkg::acc_t s,
        output cmul_pkg::acc_t cy
    );
        s  = a ^ b ^ c;
        cy = (a & b) | (b & c) | (a & c);
    endfunction

    always_comb begin
        // level one.
        csa3(terms.term[0], terms.term[1], terms.term[2], s1, c1);
        csa3(terms.term[3], terms.term[4], terms.term[5], s2, c2);

        // level two folds in the first carry.
        csa3(s1, s2, c1 << 1, s3, c3);

        // level three, both remaining carries aligned.
        csa3(s3, c2 << 1, c3 << 1, s4, c4);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= terms.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (terms.valid) begin
            sum_q   <= s4;
            carry_q <= c4;
        end
    end

    assign pair = '{valid: valid_q, sum: sum_q, carry: carry_q};

endmodule

`default_nettype wire

//--- hdl/cpa_out.sv
`timescale 1ns/1ps
`default_nettype none

module cpa_out (
    input  logic               clk,
    input  logic               rst_n,
    input  cmul_pkg::cs_pair_s pair,
    output logic               out_valid,
    output cmul_pkg::acc_t     out_product
);

    cmul_pkg::acc_t product_d;

    // the one carry-propagate add of the pipe.
    assign product_d = pair.sum + (pair.carry << 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pair.valid;
        end
    end

    // product holds its last value between strobes.
    always_ff @(posedge clk) begin
        if (pair.valid) begin
            out_product <= product_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/csd_cmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module csd_cmul_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  cmul_pkg::sample_t   in_x,
    input  cmul_pkg::coef_sel_t in_sel,
    output logic                out_valid,
    output cmul_pkg::acc_t      out_product
);

    cmul_pkg::term_bundle_s terms_s1;
    cmul_pkg::cs_pair_s     pair_s2;

    // stage 1, recipe lookup and shifted terms.
    csd_partial_gen u_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_x     (in_x),
        .in_sel   (in_sel),
        .terms    (terms_s1)
    );

    // stage 2, carry-save tree.
    csa_reduce u_reduce (
        .clk   (clk),
        .rst_n (rst_n),
        .terms (terms_s1),
        .pair  (pair_s2)
    );

    // stage 3.
    cpa_out u_cpa (
        .clk         (clk),
        .rst_n       (rst_n),
        .pair        (pair_s2),
        .out_valid   (out_valid),
        .out_product (out_product)
    );

endmodule

`default_nettype wire

//--- verif/csd_cmul_chk.sv
`timescale 1ns/1ps
`default_nettype none

module csd_cmul_chk (
    input logic           clk,
    input logic           rst_n,
    input logic           in_valid,
    input logic           out_valid,
    input cmul_pkg::acc_t out_product
);

    // every sampled strobe comes out after a fixed latency.
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_valid && rst_n, cmul_pkg::PIPE_LAT) |-> out_valid)
        else $error("out_valid missing at the fixed latency after a strobe");

    // no output without a strobe at the matching edge.
    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid && rst_n, cmul_pkg::PIPE_LAT))
        else $error("out_valid high with no strobe at the matching earlier edge");

    a_reset_clears: assert property (@(posedge clk)
        !rst_n |=> !out_valid)
        else $error("out_valid not cleared by reset");

    // product must be driven when it is flagged valid.
    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_product))
        else $error("out_product unknown while out_valid is high");

endmodule

bind csd_cmul_top csd_cmul_chk chk0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .out_valid   (out_valid),
    .out_product (out_product)
);

`default_nettype wire

//--- verif/csd_cmul_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module csd_cmul_scoreboard (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  cmul_pkg::sample_t   in_x,
    input  cmul_pkg::coef_sel_t in_sel,
    input  logic                table_known,
    input  cmul_pkg::acc_t      table_product,
    input  logic                out_valid,
    input  cmul_pkg::acc_t      out_product,
    output int                  mismatch_count,
    output int                  unexpected_count,
    output int                  checked_count,
    output int                  pending_count
);

    typedef struct packed {
        cmul_pkg::sample_t   x;
        cmul_pkg::coef_sel_t sel;
        cmul_pkg::acc_t      product;
    } expect_s;

    expect_s expected_q[$];

    int mismatches = 0;
    int unexpected = 0;
    int checked    = 0;
    int pending    = 0;

    assign mismatch_count   = mismatches;
    assign unexpected_count = unexpected;
    assign checked_count    = checked;
    assign pending_count    = pending;

    function automatic int coef_value(input cmul_pkg::coef_sel_t sel);
        case (sel)
            4'd0:    return -835;
            4'd1:    return -146;
            4'd2:    return 1221;
            4'd3:    return 367;
            4'd4:    return -1961;
            4'd5:    return -1021;
            4'd6:    return 3226;
            4'd7:    return 2242;
            4'd8:    return -5415;
            4'd9:    return -5548;
            4'd10:   return 12555;
            4'd11:   return 33782;
            default: return 0;
        endcase
    endfunction

    // wide product, then wrapped to the output width.
    function automatic cmul_pkg::acc_t model_product(input cmul_pkg::sample_t x,
                                                     input cmul_pkg::coef_sel_t sel);
        longint wide;
        wide = longint'(x) * longint'(coef_value(sel));
        return cmul_pkg::acc_t'(wide);
    endfunction

    always @(posedge clk) begin
        expect_s        head;
        cmul_pkg::acc_t model;
        // outputs first, a new strobe cannot leave on the same edge.
        if (out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                unexpected++;
                $display("unexpected out_valid at time %0t with no strobe waiting, product %0d",
                         $time, out_product);
            end else begin
                head = expected_q.pop_front();
                checked++;
                if (out_product !== head.product) begin
                    mismatches++;
                    $display("mismatch at time %0t: x %0d sel %0d expected %0d got %0d",
                             $time, head.x, head.sel, head.product, out_product);
                end
            end
        end
        if (rst_n && in_valid) begin
            model = model_product(in_x, in_sel);
            if (table_known && table_product != model) begin
                mismatches++;
                $display("mismatch at time %0t: table gives %0d for x %0d sel %0d, model gives %0d",
                         $time, table_product, in_x, in_sel, model);
            end
            expected_q.push_back('{x: in_x, sel: in_sel, product: model});
        end
        pending = expected_q.size();
    end

endmodule

`default_nettype wire

//--- verif/tb_csd_cmul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csd_cmul;

    localparam int          CLK_PERIOD      = 20;
    localparam int          DRIVE_DELAY     = 2;
    localparam int          RESET_CYCLES    = 2;
    localparam int          TABLE_LEN       = 17;
    localparam int          NUM_EDGE        = 5;
    localparam int          SWEEP_LEN       = cmul_pkg::NUM_COEF * NUM_EDGE;
    localparam int          RAND_COUNT      = 200;
    localparam int          WATCHDOG_CYCLES = (TABLE_LEN + SWEEP_LEN + RAND_COUNT) * 8 + 50;
    localparam int unsigned RAND_SEED       = 32'h22b8aec4;

    localparam cmul_pkg::sample_t EDGE_X [NUM_EDGE] = '{
        16'sh0001, 16'shffff, 16'sh0000, 16'sh7fff, 16'sh8000
    };

    typedef struct packed {
        cmul_pkg::sample_t   x;
        cmul_pkg::coef_sel_t sel;
        logic [3:0]          gap;
        cmul_pkg::acc_t      product;
    } stim_row_s;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    cmul_pkg::sample_t   in_x;
    cmul_pkg::coef_sel_t in_sel;
    logic                out_valid;
    cmul_pkg::acc_t      out_product;
    logic                table_known;
    cmul_pkg::acc_t      table_product;

    int mismatch_count;
    int unexpected_count;
    int checked_count;
    int pending_count;

    stim_row_s   stim_table [TABLE_LEN];
    int          sent_count;
    int          total_errors;

    csd_cmul_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_x        (in_x),
        .in_sel      (in_sel),
        .out_valid   (out_valid),
        .out_product (out_product)
    );

    csd_cmul_scoreboard sb0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_x             (in_x),
        .in_sel           (in_sel),
        .table_known      (table_known),
        .table_product    (table_product),
        .out_valid        (out_valid),
        .out_product      (out_product),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count),
        .checked_count    (checked_count),
        .pending_count    (pending_count)
    );

    function automatic stim_row_s make_row(input int x, input int sel, input int gap,
                                           input int product);
        return '{x: cmul_pkg::sample_t'(x), sel: cmul_pkg::coef_sel_t'(sel),
                 gap: 4'(gap), product: cmul_pkg::acc_t'(product)};
    endfunction

    // unused selects followed by a back-to-back run over every coefficient.
    task automatic load_table();
        stim_table[0]  = make_row(1, 12, 0, 0);
        stim_table[1]  = make_row(-32768, 13, 0, 0);
        stim_table[2]  = make_row(32767, 14, 1, 0);
        stim_table[3]  = make_row(12345, 15, 2, 0);
        stim_table[4]  = make_row(3, 0, 0, -2505);
        stim_table[5]  = make_row(-7, 1, 0, 1022);
        stim_table[6]  = make_row(100, 2, 0, 122100);
        stim_table[7]  = make_row(-2, 3, 0, -734);
        stim_table[8]  = make_row(10, 4, 0, -19610);
        stim_table[9]  = make_row(1000, 5, 0, -1021000);
        stim_table[10] = make_row(-3, 6, 0, -9678);
        stim_table[11] = make_row(2, 7, 0, 4484);
        stim_table[12] = make_row(-10, 8, 0, 54150);
        stim_table[13] = make_row(4, 9, 0, -22192);
        stim_table[14] = make_row(5, 10, 0, 62775);
        stim_table[15] = make_row(32767, 11, 0, 1106934794);
        stim_table[16] = make_row(-32768, 10, 4, -411402240);
    endtask

    task automatic strobe(input cmul_pkg::sample_t x, input cmul_pkg::coef_sel_t sel,
                          input logic known, input cmul_pkg::acc_t product);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid      = 1'b1;
        in_x          = x;
        in_sel        = sel;
        table_known   = known;
        table_product = product;
        sent_count++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid    = 1'b0;
            table_known = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d products still pending",
                 WATCHDOG_CYCLES, pending_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_x          = '0;
        in_sel        = '0;
        table_known   = 1'b0;
        table_product = '0;
        sent_count    = 0;
        void'($urandom(RAND_SEED));
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // extremes on every kept coefficient.
        for (int sel = 0; sel < cmul_pkg::NUM_COEF; sel++) begin
            for (int k = 0; k < NUM_EDGE; k++) begin
                strobe(EDGE_X[k], cmul_pkg::coef_sel_t'(sel), 1'b0, '0);
                idle(k % 2);
            end
        end

        for (int i = 0; i < TABLE_LEN; i++) begin
            strobe(stim_table[i].x, stim_table[i].sel, 1'b1, stim_table[i].product);
            idle(int'(stim_table[i].gap));
        end

        // zero gaps in the random mix keep the pipe full.
        for (int i = 0; i < RAND_COUNT; i++) begin
            strobe(cmul_pkg::sample_t'($urandom()),
                   cmul_pkg::coef_sel_t'($urandom_range(15, 0)), 1'b0, '0);
            idle(int'($urandom_range(2, 0)));
        end

        idle(1);
        idle(cmul_pkg::PIPE_LAT + 2);

        total_errors = mismatch_count + unexpected_count + pending_count;
        if (pending_count != 0) begin
            $display("%0d expected products never came out", pending_count);
        end
        if (checked_count != sent_count) begin
            $display("%0d strobes sent but %0d products checked", sent_count, checked_count);
            total_errors++;
        end
        $display("errors: %0d mismatches, %0d unexpected outputs, %0d left over, %0d checked",
                 mismatch_count, unexpected_count, pending_count, checked_count);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/cmul_pkg.sv
hdl/csd_partial_gen.sv
hdl/csa_reduce.sv
hdl/cpa_out.sv
hdl/csd_cmul_top.sv
verif/csd_cmul_chk.sv
verif/csd_cmul_scoreboard.sv
verif/tb_csd_cmul.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_csd_cmul
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output.
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
